//--- Bender.yml
package:
  name: layer_parser

sources:
  - common/parserPkg.sv
  - source/scanControl.sv
  - source/bankAddress.sv
  - window/windowAssembler.sv
  - source/layerParser.sv
  - target: simulation
    files:
      - dv/tbLayerParser.sv

//--- common/parserPkg.sv
package parserPkg;

	////////////////////////////////////////
	// bank and pixel sizes
	////////////////////////////////////////
	localparam int bankCount = 16;
	localparam int winSize = 4; // 4x4 window
	localparam int chanBits = 8;
	localparam int pixelBits = 4 * chanBits; // four channels
	localparam int addrBits = 9;

	typedef logic [pixelBits-1:0] pixel_t;
	typedef logic [addrBits-1:0] bankAddr_t;
	typedef logic [7:0] winIdx_t;

	////////////////////////////////////////
	// scan states
	////////////////////////////////////////
	typedef enum logic [1:0] {
		SCAN_IDLE = 2'd0,
		SCAN_ROW = 2'd1, // stepping through window slots
		SCAN_GAP = 2'd2 // pause between window rows
	} scanState_e;

	// Window origin sits at 2*idx-1, so its position mod 4 only depends on
	// the parity of the window index: 3 for even, 1 for odd.
	function automatic logic [1:0] originMod(input logic odd);
		logic [1:0] base;
		base = odd ? 2'd1 : 2'd3;
		return base;
	endfunction

endpackage

//--- dv/tbLayerParser.sv
`timescale 1ns/10ps

module tbLayerParser;

	localparam int imgCols = 16;
	localparam int imgRows = 12;
	localparam int stepCycles = 5;
	localparam int rowGap = 7;
	localparam int winCols = imgCols / 2;
	localparam int winCount = winCols * (imgRows / 2); // windows per frame
	localparam int frameCount = 2;
	localparam int memDepth = 1 << parserPkg::addrBits;

	logic clk;
	logic rstn;
	logic start;
	parserPkg::pixel_t bankData [parserPkg::bankCount];
	logic [parserPkg::bankCount-1:0] cs;
	parserPkg::bankAddr_t addr [parserPkg::bankCount];
	parserPkg::pixel_t window [parserPkg::bankCount];
	logic macVld;

	parserPkg::pixel_t img [imgRows][imgCols];
	parserPkg::pixel_t bankMem [parserPkg::bankCount][memDepth];
	logic [31:0] lcgState;
	int macCount;
	int cycleCount;
	int lastMacCycle;
	int pauseLeft;
	int waitCycles;
	logic runEnable;
	logic scanDone;
	logic heldHigh;
	logic changed;
	logic [parserPkg::bankCount-1:0] prevCs;
	parserPkg::bankAddr_t prevAddr [parserPkg::bankCount];

	layerParser #(
		.imgCols(imgCols),
		.imgRows(imgRows),
		.stepCycles(stepCycles),
		.rowGap(rowGap)
	) layerParser_i (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.bankData(bankData),
		.cs(cs),
		.addr(addr),
		.window(window),
		.macVld(macVld)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int wrapFour(input int v);
		return ((v % 4) + 4) % 4; // also for the -1 padding row
	endfunction

	function automatic parserPkg::pixel_t pixelAt(input int y, input int x);
		if (y < 0 || y >= imgRows || x < 0 || x >= imgCols) begin
			return '0;
		end
		return img[y][x];
	endfunction

	task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s (got %0h, expected %0h)",
				$time, what, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic loadImage();
		for (int b = 0; b < parserPkg::bankCount; b++) begin
			for (int a = 0; a < memDepth; a++) begin
				bankMem[b][a] = {8'hC3, 8'(b), 7'd0, 9'(a)}; // never part of a window
			end
		end
		for (int y = 0; y < imgRows; y++) begin
			for (int x = 0; x < imgCols; x++) begin
				img[y][x] = nextRand();
				bankMem[4 * (y % 4) + (x % 4)][(y / 4) * (imgCols / 4) + x / 4] = img[y][x];
			end
		end
	endtask

	task automatic verifyWindow(input int pos);
		int r = pos / winCols;
		int c = pos % winCols;
		for (int k = 0; k < parserPkg::bankCount; k++) begin
			compareValue(window[k], pixelAt(2 * r - 1 + k / 4, 2 * c - 1 + k % 4),
				$sformatf("window (%0d,%0d) slot %0d", r, c, k));
		end
	endtask

	task automatic auditBanks(input int pos);
		int r = pos / winCols;
		int c = pos % winCols;
		int y, x, b;
		logic inImage;
		for (int k = 0; k < parserPkg::bankCount; k++) begin
			y = 2 * r - 1 + k / 4;
			x = 2 * c - 1 + k % 4;
			b = 4 * wrapFour(y) + wrapFour(x);
			inImage = (y >= 0) && (y < imgRows) && (x >= 0) && (x < imgCols);
			compareValue(cs[b], inImage, $sformatf("cs of bank %0d at (%0d,%0d)", b, r, c));
			if (inImage) begin
				compareValue(addr[b], (y / 4) * (imgCols / 4) + x / 4,
					$sformatf("addr of bank %0d at (%0d,%0d)", b, r, c));
			end
		end
	endtask

	////////////////////////////////////////
	// clock, RAM model, start driver
	////////////////////////////////////////
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		for (int b = 0; b < parserPkg::bankCount; b++) begin
			if (cs[b]) begin
				bankData[b] <= bankMem[b][addr[b]]; // registered read
			end else begin
				bankData[b] <= '1; // junk, must be masked
			end
		end
	end

	always @(posedge clk) begin
		if (!runEnable || scanDone) begin
			start <= 1'b0;
		end else if (pauseLeft > 0) begin
			start <= 1'b0;
			pauseLeft <= pauseLeft - 1;
		end else begin
			start <= 1'b1;
			if ((nextRand() >> 16) % 20 == 0) begin
				pauseLeft <= (nextRand() >> 16) % 11;
			end
		end
	end

	////////////////////////////////////////
	// monitor
	////////////////////////////////////////
	always @(negedge clk) begin
		if (rstn) begin
			cycleCount++;
			if (!start) heldHigh = 1'b0;
			changed = (cs !== prevCs);
			for (int b = 0; b < parserPkg::bankCount; b++) begin
				if (addr[b] !== prevAddr[b]) changed = 1'b1;
				prevAddr[b] = addr[b];
			end
			prevCs = cs;
			if (changed) auditBanks(macCount % winCount); // phase 1 of the slot
			if (macVld) begin
				compareValue(start, 1'b1, "macVld while start low");
				verifyWindow(macCount % winCount);
				auditBanks(macCount % winCount);
				if (macCount % winCols == 0 && macCount % winCount != 0 && heldHigh) begin
					compareValue(cycleCount - lastMacCycle >= rowGap + stepCycles, 1'b1,
						"row gap too short");
				end
				lastMacCycle = cycleCount;
				heldHigh = 1'b1;
				macCount++;
				if (macCount == frameCount * winCount) scanDone = 1'b1;
			end
		end
	end

	initial begin
		lcgState = 32'd45457;
		macCount = 0;
		cycleCount = 0;
		lastMacCycle = 0;
		pauseLeft = 0;
		runEnable = 1'b0;
		scanDone = 1'b0;
		heldHigh = 1'b0;
		prevCs = '0;
		rstn = 1'b0;
		start = 1'b0;
		for (int b = 0; b < parserPkg::bankCount; b++) begin
			bankData[b] = '0;
			prevAddr[b] = '0;
		end
		loadImage();
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		repeat (4) begin
			@(negedge clk);
			compareValue(macVld, 1'b0, "macVld before start");
			compareValue(cs, '0, "cs before start");
		end
		runEnable = 1'b1;
		waitCycles = 0;
		while (macCount < frameCount * winCount && waitCycles < 4000) begin
			@(negedge clk);
			waitCycles++;
		end
		if (macCount < frameCount * winCount) begin
			$display("Timed out waiting for the macVld pulses of both frames");
			$display("CHECKS FAILED");
			$fatal(1, "scan did not finish");
		end else begin
			repeat (40) @(negedge clk); // start is low now, scan must stay idle
			compareValue(macCount, frameCount * winCount, "total macVld pulses");
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- list.f
common/parserPkg.sv
source/scanControl.sv
source/bankAddress.sv
window/windowAssembler.sv
source/layerParser.sv
dv/tbLayerParser.sv

//--- source/bankAddress.sv
`timescale 1ns/10ps

module bankAddress #(
	parameter int imgCols = 32,
	parameter int imgRows = 32
) (
	input logic clk,
	input logic rstn,
	input parserPkg::winIdx_t winRow,
	input parserPkg::winIdx_t winCol,
	input logic loadWin,
	output logic [parserPkg::bankCount-1:0] cs,
	output parserPkg::bankAddr_t addr [parserPkg::bankCount]
);

	localparam int wordsPerRow = imgCols / parserPkg::winSize;

	logic [1:0] rowBase;
	logic [1:0] colBase;
	logic [parserPkg::bankCount-1:0] csNext;
	parserPkg::bankAddr_t addrNext [parserPkg::bankCount];

	assign rowBase = parserPkg::originMod(winRow[0]);
	assign colBase = parserPkg::originMod(winCol[0]);

	////////////////////////////////////////
	// which window pixel each bank serves
	////////////////////////////////////////
	always_comb begin
		logic [1:0] wr;
		logic [1:0] wc;
		int pixRow;
		int pixCol;
		logic inImage;
		for (int b = 0; b < parserPkg::bankCount; b++) begin
			wr = 2'(b / parserPkg::winSize) - rowBase; // wraps mod 4
			wc = 2'(b % parserPkg::winSize) - colBase;
			pixRow = 2 * int'(winRow) - 1 + int'(wr);
			pixCol = 2 * int'(winCol) - 1 + int'(wc);
			inImage = (pixRow >= 0) && (pixRow < imgRows)
				&& (pixCol >= 0) && (pixCol < imgCols);
			csNext[b] = inImage;
			if (inImage) begin
				addrNext[b] = parserPkg::bankAddr_t'(
					(pixRow / parserPkg::winSize) * wordsPerRow
					+ pixCol / parserPkg::winSize);
			end else begin
				addrNext[b] = '0; // padding, bank idle
			end
		end
	end

	////////////////////////////////////////
	// registered at the end of phase 0
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cs <= '0;
			for (int b = 0; b < parserPkg::bankCount; b++) begin
				addr[b] <= '0;
			end
		end else if (loadWin) begin
			cs <= csNext;
			for (int b = 0; b < parserPkg::bankCount; b++) begin
				addr[b] <= addrNext[b];
			end
		end
	end

endmodule

//--- source/layerParser.sv
`timescale 1ns/10ps

module layerParser #(
	parameter int imgCols = 32,
	parameter int imgRows = 32,
	parameter int stepCycles = 5,
	parameter int rowGap = 7
) (
	input logic clk,
	input logic rstn,
	input logic start,
	input parserPkg::pixel_t bankData [parserPkg::bankCount],
	output logic [parserPkg::bankCount-1:0] cs,
	output parserPkg::bankAddr_t addr [parserPkg::bankCount],
	output parserPkg::pixel_t window [parserPkg::bankCount],
	output logic macVld
);

	parserPkg::winIdx_t winRow;
	parserPkg::winIdx_t winCol;
	logic loadWin; // slot phase 0
	logic capture; // slot phase 2

	scanControl #(
		.imgCols(imgCols),
		.imgRows(imgRows),
		.stepCycles(stepCycles),
		.rowGap(rowGap)
	) scanControl_i (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.winRow(winRow),
		.winCol(winCol),
		.loadWin(loadWin),
		.capture(capture),
		.macVld(macVld)
	);

	bankAddress #(
		.imgCols(imgCols),
		.imgRows(imgRows)
	) bankAddress_i (
		.clk(clk),
		.rstn(rstn),
		.winRow(winRow),
		.winCol(winCol),
		.loadWin(loadWin),
		.cs(cs),
		.addr(addr)
	);

	windowAssembler windowAssembler_i (
		.clk(clk),
		.rstn(rstn),
		.capture(capture),
		.winRow(winRow),
		.winCol(winCol),
		.cs(cs),
		.bankData(bankData),
		.window(window)
	);

endmodule

//--- source/scanControl.sv
`timescale 1ns/10ps

module scanControl #(
	parameter int imgCols = 32,
	parameter int imgRows = 32,
	parameter int stepCycles = 5,
	parameter int rowGap = 7
) (
	input logic clk,
	input logic rstn,
	input logic start,
	output parserPkg::winIdx_t winRow,
	output parserPkg::winIdx_t winCol,
	output logic loadWin,
	output logic capture,
	output logic macVld
);

	localparam int winCols = imgCols / 2; // stride 2, one pixel padding
	localparam int winRows = imgRows / 2;
	localparam int phaseBits = $clog2(stepCycles);
	localparam int gapBits = $clog2(rowGap + 1);

	parserPkg::scanState_e state;
	logic [phaseBits-1:0] phase;
	logic [gapBits-1:0] gapCnt;

	logic slotEnd;
	logic colEnd;
	logic rowEnd;
	logic gapEnd;
	logic inRow;

	assign slotEnd = (phase == phaseBits'(stepCycles - 1));
	assign colEnd = (winCol == parserPkg::winIdx_t'(winCols - 1));
	assign rowEnd = (winRow == parserPkg::winIdx_t'(winRows - 1));
	assign gapEnd = (gapCnt == gapBits'(rowGap - 1));

	////////////////////////////////////////
	// scan FSM and counters
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= parserPkg::SCAN_IDLE;
			phase <= '0;
			gapCnt <= '0;
			winRow <= '0;
			winCol <= '0;
		end else if (start) begin // start low freezes everything
			case (state)
				parserPkg::SCAN_IDLE: begin
					state <= parserPkg::SCAN_ROW;
				end
				parserPkg::SCAN_ROW: begin
					if (!slotEnd) begin
						phase <= phase + 1'b1;
					end else begin
						phase <= '0;
						if (!colEnd) begin
							winCol <= winCol + 1'b1;
						end else if (!rowEnd) begin
							winCol <= '0;
							gapCnt <= '0;
							state <= parserPkg::SCAN_GAP;
						end else begin
							winCol <= '0; // frame done
							winRow <= '0;
							state <= parserPkg::SCAN_IDLE;
						end
					end
				end
				parserPkg::SCAN_GAP: begin
					if (gapEnd) begin
						gapCnt <= '0;
						winRow <= winRow + 1'b1;
						state <= parserPkg::SCAN_ROW;
					end else begin
						gapCnt <= gapCnt + 1'b1;
					end
				end
				default: begin
					state <= parserPkg::SCAN_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// slot strobes
	////////////////////////////////////////
	assign inRow = start && (state == parserPkg::SCAN_ROW);
	assign loadWin = inRow && (phase == '0); // position valid
	assign capture = inRow && (phase == phaseBits'(2)); // ram data valid
	assign macVld = inRow && slotEnd;

endmodule

//--- window/windowAssembler.sv
`timescale 1ns/10ps

module windowAssembler (
	input logic clk,
	input logic rstn,
	input logic capture,
	input parserPkg::winIdx_t winRow,
	input parserPkg::winIdx_t winCol,
	input logic [parserPkg::bankCount-1:0] cs,
	input parserPkg::pixel_t bankData [parserPkg::bankCount],
	output parserPkg::pixel_t window [parserPkg::bankCount]
);

	parserPkg::pixel_t dataLat [parserPkg::bankCount];
	logic [parserPkg::bankCount-1:0] csLat;
	logic rowOdd;
	logic colOdd;
	logic [1:0] rowBase;
	logic [1:0] colBase;

	////////////////////////////////////////
	// capture at the end of phase 2
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (capture) begin
			for (int b = 0; b < parserPkg::bankCount; b++) begin
				dataLat[b] <= bankData[b];
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			csLat <= '0; // window reads as zero
			rowOdd <= 1'b0;
			colOdd <= 1'b0;
		end else if (capture) begin
			csLat <= cs;
			rowOdd <= winRow[0]; // parity of the captured position
			colOdd <= winCol[0];
		end
	end

	assign rowBase = parserPkg::originMod(rowOdd);
	assign colBase = parserPkg::originMod(colOdd);

	////////////////////////////////////////
	// rotate into window order
	////////////////////////////////////////
	// Slot k = 4*wr+wc reads image pixel (2R-1+wr, 2C-1+wc), which lives in
	// the bank indexed by those coordinates mod 4.
	always_comb begin
		logic [1:0] bankRow;
		logic [1:0] bankCol;
		int bank;
		for (int k = 0; k < parserPkg::bankCount; k++) begin
			bankRow = rowBase + 2'(k / parserPkg::winSize);
			bankCol = colBase + 2'(k % parserPkg::winSize);
			bank = parserPkg::winSize * int'(bankRow) + int'(bankCol);
			if (csLat[bank]) begin
				window[k] = dataLat[bank];
			end else begin
				window[k] = '0; // zero padding
			end
		end
	end

endmodule
